// ==== src/icache_pkg.sv ====
package icache_pkg;

    // address and data widths
    parameter int WORD_W          = 32;
    parameter int WORD_ADDR_W     = 30;
    parameter int WORDS_PER_BLOCK = 4;
    parameter int OFFSET_W        = $clog2(WORDS_PER_BLOCK);
    parameter int BLOCK_ADDR_W    = WORD_ADDR_W - OFFSET_W;
    parameter int BLOCK_W         = WORD_W * WORDS_PER_BLOCK;

    // default geometry of the cache
    parameter int DEFAULT_NUM_BLOCKS = 8;

    // processor word address
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;

    // memory block address, the word address without its offset bits
    typedef logic [BLOCK_ADDR_W-1:0] block_addr_t;

    typedef logic [WORD_W-1:0] word_t;

    // word n sits at bits 32n+31 down to 32n
    typedef logic [BLOCK_W-1:0] block_t;

    // refill FSM of the cache
    typedef enum logic [1:0] {
        IDLE,
        REFILL,
        FILL
    } cache_state_t;

endpackage

// ==== src/mem_refill_if.sv ====
`timescale 1ns/1ps

interface mem_refill_if;

    // request side, driven by the cache
    logic                     req;
    icache_pkg::block_addr_t  addr;

    // response side, driven by the register stage
    icache_pkg::block_t       rdata;
    logic                     ack;

    // req holds with addr stable until ack
    // rdata is valid while ack is high
    modport cache (
        output req,
        output addr,
        input  rdata,
        input  ack
    );

    modport port (
        input  req,
        input  addr,
        output rdata,
        output ack
    );

endinterface

// ==== src/icache_dm.sv ====
`timescale 1ns/1ps

module icache_dm #(
    parameter int NUM_BLOCKS = 8
) (
    input  logic                    clk,
    input  logic                    proc_reset,
    input  logic                    proc_read,
    input  icache_pkg::word_addr_t  proc_addr,
    output icache_pkg::word_t       proc_rdata,
    output logic                    proc_stall,
    mem_refill_if.cache             mem
);

    localparam int IDX_W = $clog2(NUM_BLOCKS);
    localparam int TAG_W = icache_pkg::BLOCK_ADDR_W - IDX_W;

    icache_pkg::cache_state_t state;
    icache_pkg::cache_state_t next_state;

    // line storage
    logic [NUM_BLOCKS-1:0]   valid;
    logic [TAG_W-1:0]        tag_mem  [NUM_BLOCKS];
    icache_pkg::block_t      data_mem [NUM_BLOCKS];

    // address split
    icache_pkg::block_addr_t             blk_addr;
    logic [IDX_W-1:0]                    line_idx;
    logic [TAG_W-1:0]                    line_tag;
    logic [icache_pkg::OFFSET_W-1:0]     word_sel;

    icache_pkg::block_t  line_data;
    logic                hit;
    logic                miss_req;

    assign blk_addr = proc_addr[icache_pkg::WORD_ADDR_W-1:icache_pkg::OFFSET_W];
    assign word_sel = proc_addr[icache_pkg::OFFSET_W-1:0];
    assign line_idx = blk_addr[IDX_W-1:0];
    assign line_tag = blk_addr[icache_pkg::BLOCK_ADDR_W-1:IDX_W];

    // lookup, combinational from the array
    assign line_data = data_mem[line_idx];
    assign hit       = valid[line_idx] && (tag_mem[line_idx] == line_tag);

    assign proc_rdata = line_data[word_sel*icache_pkg::WORD_W +: icache_pkg::WORD_W];

    // the held read only hits again once the FSM is back in IDLE
    assign proc_stall = proc_read && ((state != icache_pkg::IDLE) || !hit);

    // new miss seen in IDLE
    assign miss_req = (state == icache_pkg::IDLE) && proc_read && !hit;

    // request goes out in the miss cycle and stays up through the ack cycle
    assign mem.req  = miss_req || (state == icache_pkg::REFILL);
    assign mem.addr = blk_addr;

    always_comb begin
        next_state = state;
        case (state)
            icache_pkg::IDLE: begin
                if (miss_req) begin
                    next_state = icache_pkg::REFILL;
                end
            end
            icache_pkg::REFILL: begin
                if (mem.ack) begin
                    next_state = icache_pkg::FILL;
                end
            end
            icache_pkg::FILL: begin
                // single cycle to write the line
                next_state = icache_pkg::IDLE;
            end
            default: begin
                next_state = icache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state <= icache_pkg::IDLE;
            valid <= '0;
        end else begin
            state <= next_state;
            if (state == icache_pkg::FILL) begin
                valid[line_idx] <= 1'b1;
            end
        end
    end

    // tag and data written from the block held by the register stage
    always_ff @(posedge clk) begin
        if (state == icache_pkg::FILL) begin
            tag_mem[line_idx]  <= line_tag;
            data_mem[line_idx] <= mem.rdata;
        end
    end

endmodule

// ==== src/mem_port_reg.sv ====
`timescale 1ns/1ps

module mem_port_reg (
    input  logic                     clk,
    input  logic                     proc_reset,
    mem_refill_if.port               cache_side,
    input  logic                     mem_ready,
    input  icache_pkg::block_t       mem_rdata,
    output logic                     mem_read,
    output icache_pkg::block_addr_t  mem_addr
);

    logic                     mem_read_r;
    logic                     ack_r;
    icache_pkg::block_addr_t  mem_addr_r;
    icache_pkg::block_t       rdata_r;

    // control registers
    always_ff @(posedge clk) begin
        if (proc_reset) begin
            mem_read_r <= 1'b0;
            ack_r      <= 1'b0;
        end else begin
            // drop on acknowledge, and keep low while the cache
            // still shows req in its ack cycle
            mem_read_r <= cache_side.req && !mem_ready && !ack_r;
            ack_r      <= mem_ready;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (cache_side.req) begin
            mem_addr_r <= cache_side.addr;
        end
        // last acknowledged block stays until the next refill
        if (mem_ready) begin
            rdata_r <= mem_rdata;
        end
    end

    assign mem_read = mem_read_r;
    assign mem_addr = mem_addr_r;

    assign cache_side.ack   = ack_r;
    assign cache_side.rdata = rdata_r;

endmodule

// ==== src/cache_pmu.sv ====
`timescale 1ns/1ps

module cache_pmu (
    input  logic         clk,
    input  logic         proc_reset,
    input  logic         proc_read,
    input  logic         proc_write,
    input  logic         proc_stall,
    output logic [31:0]  read_count,
    output logic [31:0]  write_count,
    output logic [31:0]  read_miss,
    output logic [31:0]  read_stalled_cycles
);

    logic stall_q;
    logic read_accepted;
    logic stall_rise;
    logic read_stalled;

    // a read counts once, in the cycle it completes
    assign read_accepted = proc_read && !proc_stall;

    // every miss starts a fresh stall
    assign stall_rise = proc_stall && !stall_q;

    assign read_stalled = proc_read && proc_stall;

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            stall_q             <= 1'b0;
            read_count          <= '0;
            write_count         <= '0;
            read_miss           <= '0;
            read_stalled_cycles <= '0;
        end else begin
            stall_q <= proc_stall;
            if (read_accepted) begin
                read_count <= read_count + 32'd1;
            end
            // writes are not cached, only counted per cycle
            if (proc_write) begin
                write_count <= write_count + 32'd1;
            end
            if (stall_rise) begin
                read_miss <= read_miss + 32'd1;
            end
            if (read_stalled) begin
                read_stalled_cycles <= read_stalled_cycles + 32'd1;
            end
        end
    end

endmodule

// ==== src/icache_wrapper.sv ====
`timescale 1ns/1ps

module icache_wrapper #(
    parameter int NUM_BLOCKS = icache_pkg::DEFAULT_NUM_BLOCKS
) (
    input  logic                     clk,
    input  logic                     proc_reset,
    input  logic                     proc_read,
    input  logic                     proc_write,
    input  icache_pkg::word_addr_t   proc_addr,
    output icache_pkg::word_t        proc_rdata,
    output logic                     proc_stall,
    input  logic                     mem_ready,
    input  icache_pkg::block_t       mem_rdata,
    output logic                     mem_read,
    output icache_pkg::block_addr_t  mem_addr,
    output logic [31:0]              read_count,
    output logic [31:0]              write_count,
    output logic [31:0]              read_miss,
    output logic [31:0]              read_stalled_cycles
);

    // refill path between lookup stage and memory register stage
    mem_refill_if refill ();

    icache_dm #(
        .NUM_BLOCKS (NUM_BLOCKS)
    ) u_icache_dm (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_addr  (proc_addr),
        .proc_rdata (proc_rdata),
        .proc_stall (proc_stall),
        .mem        (refill.cache)
    );

    mem_port_reg u_mem_port_reg (
        .clk        (clk),
        .proc_reset (proc_reset),
        .cache_side (refill.port),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .mem_read   (mem_read),
        .mem_addr   (mem_addr)
    );

    // statistics watch the processor side only
    cache_pmu u_cache_pmu (
        .clk                 (clk),
        .proc_reset          (proc_reset),
        .proc_read           (proc_read),
        .proc_write          (proc_write),
        .proc_stall          (proc_stall),
        .read_count          (read_count),
        .write_count         (write_count),
        .read_miss           (read_miss),
        .read_stalled_cycles (read_stalled_cycles)
    );

endmodule

// ==== sim/icache_asserts.sv ====
`timescale 1ns/1ps

module icache_asserts (
    input  logic                      clk,
    input  logic                      proc_reset,
    input  logic                      proc_read,
    input  logic                      proc_stall,
    input  icache_pkg::cache_state_t  state,
    input  logic                      req_valid,
    input  icache_pkg::block_addr_t   req_addr,
    input  logic                      req_ack
);

    // address holds until memory answers
    a_addr_stable: assert property (@(posedge clk) disable iff (proc_reset)
        (req_valid && !req_ack) |=> $stable(req_addr))
        else $error("request address changed before the acknowledge");

    a_drop_after_ack: assert property (@(posedge clk) disable iff (proc_reset)
        req_ack |=> !req_valid)
        else $error("request still high in the cycle after the acknowledge");

    a_stall_needs_read: assert property (@(posedge clk) disable iff (proc_reset)
        $rose(proc_stall) |-> proc_read)
        else $error("proc_stall rose without proc_read");

    // line write takes a single cycle
    a_fill_one_cycle: assert property (@(posedge clk) disable iff (proc_reset)
        (state == icache_pkg::FILL) |=> (state != icache_pkg::FILL))
        else $error("refill FSM stayed in FILL");

endmodule

// refill handshake as the cache sees it
bind icache_dm icache_asserts u_dm_asserts (
    .clk        (clk),
    .proc_reset (proc_reset),
    .proc_read  (proc_read),
    .proc_stall (proc_stall),
    .state      (state),
    .req_valid  (mem.req),
    .req_addr   (mem.addr),
    .req_ack    (mem.ack)
);

bind mem_port_reg icache_asserts u_port_asserts (
    .clk        (clk),
    .proc_reset (proc_reset),
    .proc_read  (1'b0),
    .proc_stall (1'b0),
    .state      (icache_pkg::IDLE),
    .req_valid  (mem_read),
    .req_addr   (mem_addr),
    .req_ack    (mem_ready)
);

// ==== sim/tb_icache.sv ====
`timescale 1ns/1ps

module tb_icache;

    localparam int NUM_LINES   = 8;
    localparam int IDX_W       = $clog2(NUM_LINES);
    localparam int TAG_W       = 28 - IDX_W;
    localparam int STALL_LIMIT = 40;
    localparam int RANDOM_OPS  = 200;

    localparam logic [31:0] FILL_PATTERN = 32'hA5C3_0F96;
    localparam logic [29:0] BASE_ADDR    = 30'h0000_4000;

    logic                     clk;
    logic                     proc_reset;
    logic                     proc_read;
    logic                     proc_write;
    icache_pkg::word_addr_t   proc_addr;
    icache_pkg::word_t        proc_rdata;
    logic                     proc_stall;
    logic                     mem_ready;
    icache_pkg::block_t       mem_rdata;
    logic                     mem_read;
    icache_pkg::block_addr_t  mem_addr;
    logic [31:0]              read_count;
    logic [31:0]              write_count;
    logic [31:0]              read_miss;
    logic [31:0]              read_stalled_cycles;

    // reference model of the tag and valid arrays
    logic              m_valid [NUM_LINES];
    logic [TAG_W-1:0]  m_tag   [NUM_LINES];

    logic [31:0]  rng_state;
    logic [27:0]  exp_blk;
    logic [27:0]  mem_hold_addr;
    int           mem_delay;
    int           mem_reqs;
    int           errors;
    int           tests_run;
    int           tests_failed;
    int           reads;
    int           writes;
    int           misses;
    int           stall_cycles;
    int           start_errors;
    bit           aborted;

    icache_wrapper #(
        .NUM_BLOCKS (NUM_LINES)
    ) i_icache_wrapper (
        .clk                 (clk),
        .proc_reset          (proc_reset),
        .proc_read           (proc_read),
        .proc_write          (proc_write),
        .proc_addr           (proc_addr),
        .proc_rdata          (proc_rdata),
        .proc_stall          (proc_stall),
        .mem_ready           (mem_ready),
        .mem_rdata           (mem_rdata),
        .mem_read            (mem_read),
        .mem_addr            (mem_addr),
        .read_count          (read_count),
        .write_count         (write_count),
        .read_miss           (read_miss),
        .read_stalled_cycles (read_stalled_cycles)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // word n of a block is its word address with the fill pattern applied
    function automatic logic [31:0] expected_word(input logic [29:0] addr);
        logic [31:0] word_addr;
        word_addr = {4'b0, addr[29:2]} * 32'd4 + {30'b0, addr[1:0]};
        return word_addr ^ FILL_PATTERN;
    endfunction

    function automatic icache_pkg::block_t memory_block(input logic [27:0] blk);
        icache_pkg::block_t data;
        for (int n = 0; n < 4; n++) begin
            data[32*n +: 32] = expected_word({blk, 2'(n)});
        end
        return data;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got=%0h expected=%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        tests_run++;
        if (aborted) begin
            $display("test %s: stopped by a timeout", name);
            tests_failed++;
        end else if (errors == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d mismatches", name, errors - errors_at_start);
            tests_failed++;
        end
    endtask

    task automatic idle_cycle(input logic wr);
        @(posedge clk);
        proc_read  <= 1'b0;
        proc_write <= wr;
        if (wr) begin
            writes++;
        end
    endtask

    // one read, held until proc_stall falls
    task automatic do_read(input logic [29:0] addr);
        logic [27:0]       blk;
        logic [IDX_W-1:0]  idx;
        logic [TAG_W-1:0]  tag;
        logic              predicted_hit;
        int                cycles;
        int                reqs_before;
        blk           = addr[29:2];
        idx           = blk[IDX_W-1:0];
        tag           = blk[27:IDX_W];
        predicted_hit = m_valid[idx] && (m_tag[idx] == tag);
        reqs_before   = mem_reqs;
        exp_blk       = blk;
        @(posedge clk);
        proc_read  <= 1'b1;
        proc_write <= 1'b0;
        proc_addr  <= addr;
        @(negedge clk);
        compare_value("proc_stall", proc_stall, !predicted_hit);
        cycles = 0;
        while (proc_stall && cycles < STALL_LIMIT) begin
            stall_cycles++;
            @(negedge clk);
            cycles++;
        end
        if (proc_stall) begin
            $display("timeout: read of address %h still stalled after %0d cycles",
                     addr, STALL_LIMIT);
            aborted = 1'b1;
        end else begin
            compare_value("proc_rdata", proc_rdata, expected_word(addr));
            compare_value("mem_read requests", mem_reqs - reqs_before,
                          predicted_hit ? 0 : 1);
            reads++;
            if (!predicted_hit) begin
                misses++;
            end
            m_valid[idx] = 1'b1;
            m_tag[idx]   = tag;
        end
    endtask

    // memory model, answers after 1 to 4 cycles
    always begin
        @(negedge clk);
        if (mem_read && !proc_reset) begin
            mem_reqs++;
            compare_value("mem_addr", mem_addr, exp_blk);
            mem_hold_addr = mem_addr;
            mem_delay     = 1 + int'(next_rand() % 4);
            for (int k = 0; k < mem_delay; k++) begin
                @(negedge clk);
                compare_value("mem_read", mem_read, 1'b1);
                compare_value("mem_addr", mem_addr, mem_hold_addr);
            end
            @(posedge clk);
            mem_ready <= 1'b1;
            mem_rdata <= memory_block(mem_hold_addr);
            @(posedge clk);
            mem_ready <= 1'b0;
        end
    end

    initial begin
        clk        = 1'b0;
        proc_reset = 1'b1;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        mem_ready  = 1'b0;
        mem_rdata  = '0;
        rng_state  = 32'd43;
        for (int i = 0; i < NUM_LINES; i++) begin
            m_valid[i] = 1'b0;
            m_tag[i]   = '0;
        end

        repeat (2) @(posedge clk);
        proc_reset <= 1'b0;

        start_errors = errors;
        @(negedge clk);
        compare_value("proc_stall", proc_stall, 1'b0);
        compare_value("mem_read", mem_read, 1'b0);
        compare_value("read_count", read_count, 0);
        compare_value("write_count", write_count, 0);
        compare_value("read_miss", read_miss, 0);
        compare_value("read_stalled_cycles", read_stalled_cycles, 0);
        finish_test("reset_state", start_errors);

        // miss, then hits on the same block
        start_errors = errors;
        do_read(BASE_ADDR + 30'd4);
        if (!aborted) do_read(BASE_ADDR + 30'd4);
        if (!aborted) do_read(BASE_ADDR + 30'd7);
        finish_test("hit_and_miss", start_errors);

        // same line, other tag
        if (!aborted) begin
            start_errors = errors;
            do_read(BASE_ADDR + 30'd36);
            if (!aborted) do_read(BASE_ADDR + 30'd4);
            if (!aborted) do_read(BASE_ADDR + 30'd36);
            finish_test("conflict_eviction", start_errors);
        end

        if (!aborted) begin
            start_errors = errors;
            for (int i = 0; i < RANDOM_OPS && !aborted; i++) begin
                logic [31:0] r;
                r = next_rand();
                if (r[1:0] == 2'd0) begin
                    idle_cycle(r[2]);
                end else begin
                    do_read(BASE_ADDR + {23'b0, r[10:4]});
                end
            end
            finish_test("random_run", start_errors);
        end

        if (!aborted) begin
            start_errors = errors;
            idle_cycle(1'b0);
            idle_cycle(1'b0);
            @(negedge clk);
            compare_value("read_count", read_count, reads);
            compare_value("write_count", write_count, writes);
            compare_value("read_miss", read_miss, misses);
            compare_value("read_stalled_cycles", read_stalled_cycles, stall_cycles);
            finish_test("counters", start_errors);
        end

        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0 && !aborted) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
src/icache_pkg.sv
src/mem_refill_if.sv
src/icache_dm.sv
src/mem_port_reg.sv
src/cache_pmu.sv
src/icache_wrapper.sv
sim/icache_asserts.sv
sim/tb_icache.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_icache -f vlog.f -o sim_icache

./obj_dir/sim_icache | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "simulation result: pass"
else
    echo "simulation result: fail"
    exit 1
fi
